// ==== rtl/wb_macros.svh ====
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

// store queue
`define WB_QUEUE_DEPTH 4

// entries per register file
`define WB_NUM_REGS 8

// p_op bits that mark a far transfer
`define WB_POP_FAR_JMP  36
`define WB_POP_FAR_CALL 35
`define WB_POP_FAR_RET  32

// even/odd 16-byte fetch line select
`define WB_LINE_BIT 4

// CS position in the segment file
`define WB_CS_INDEX 1

`endif

// ==== rtl/arch_pkg.sv ====
package arch_pkg;

    // general register value
    typedef logic [31:0] gpr_val_t;

    // register or segment index
    typedef logic [2:0] reg_idx_t;

    // segment selector
    typedef logic [15:0] seg_sel_t;

    // instruction pointer or linear address
    typedef logic [31:0] eip_t;

endpackage

// ==== rtl/pipe_pkg.sv ====
package pipe_pkg;

    // one result slot of a retiring instruction
    typedef logic [63:0] slot_data_t;

    // 0 byte, 1 word, 2 dword, 3 qword
    typedef logic [1:0] op_size_t;

    typedef logic [3:0] ie_type_t;

    // micro-op control word
    typedef logic [36:0] p_op_t;

    // {addr[31:0], data[63:0], size[1:0]}
    typedef logic [97:0] wbaq_entry_t;

    // four-phase drain handshake
    typedef enum logic [1:0] {
        idle,
        req,
        wait_release
    } drain_state_t;

endpackage

// ==== rtl/writeback_stage.sv ====
`timescale 1ns/100ps
`include "wb_macros.svh"

module writeback_stage
    import arch_pkg::*;
    import pipe_pkg::*;
(
    input  logic       valid_in,
    input  p_op_t      p_op,
    input  op_size_t   op_size,
    input  slot_data_t slot1_data,
    input  slot_data_t slot2_data,
    input  slot_data_t slot3_data,
    input  slot_data_t slot4_data,
    input  eip_t       slot1_dest,
    input  eip_t       slot2_dest,
    input  eip_t       slot3_dest,
    input  eip_t       slot4_dest,
    input  logic       slot1_is_reg,
    input  logic       slot2_is_reg,
    input  logic       slot3_is_reg,
    input  logic       slot4_is_reg,
    input  logic       slot1_is_seg,
    input  logic       slot2_is_seg,
    input  logic       slot3_is_seg,
    input  logic       slot4_is_seg,
    input  logic       slot1_is_mem,
    input  logic       slot2_is_mem,
    input  logic       slot3_is_mem,
    input  logic       slot4_is_mem,
    input  logic       slot1_wb,
    input  logic       slot2_wb,
    input  logic       slot3_wb,
    input  logic       slot4_wb,
    input  eip_t       eip_in,
    input  logic       br_valid_in,
    input  logic       br_taken_in,
    input  logic       br_correct_in,
    input  eip_t       br_fip,
    input  eip_t       br_fip_p1,
    input  logic       ie_in,
    input  ie_type_t   ie_type_in,
    input  logic       interrupt_in,
    input  logic       full,
    output logic       valid_out,
    output logic       stall,
    output logic [3:0] gpr_ld,
    output logic [3:0] seg_ld,
    output reg_idx_t   dest_idx1,
    output reg_idx_t   dest_idx2,
    output reg_idx_t   dest_idx3,
    output reg_idx_t   dest_idx4,
    output slot_data_t wr_data1,
    output slot_data_t wr_data2,
    output slot_data_t wr_data3,
    output slot_data_t wr_data4,
    output logic       cs_ld,
    output seg_sel_t   cs_sel,
    output logic       push,
    output eip_t       push_addr,
    output slot_data_t push_data,
    output op_size_t   push_size,
    output logic       is_resteer,
    output eip_t       new_eip,
    output eip_t       new_fip_e,
    output eip_t       new_fip_o,
    output logic       final_ie_val,
    output ie_type_t   final_ie_type
);

    logic [3:0] is_mem;
    logic       far_xfer;
    logic       store_present;
    eip_t       target_eip;
    eip_t       fip_al;
    eip_t       fip_p1_al;

    assign is_mem   = {slot4_is_mem, slot3_is_mem, slot2_is_mem, slot1_is_mem};
    assign far_xfer = p_op[`WB_POP_FAR_JMP] | p_op[`WB_POP_FAR_CALL] | p_op[`WB_POP_FAR_RET];

    // stall only matters when a store is actually offered
    assign store_present = valid_in & (|is_mem);
    assign stall         = full & store_present;
    assign valid_out     = valid_in & ~stall;

    assign gpr_ld = {slot4_is_reg & slot4_wb, slot3_is_reg & slot3_wb,
                     slot2_is_reg & slot2_wb, slot1_is_reg & slot1_wb} & {4{valid_out}};
    assign seg_ld = {slot4_is_seg & slot4_wb, slot3_is_seg & slot3_wb,
                     slot2_is_seg & slot2_wb, slot1_is_seg & slot1_wb} & {4{valid_out}};

    assign dest_idx1 = slot1_dest[2:0];
    assign dest_idx2 = slot2_dest[2:0];
    assign dest_idx3 = slot3_dest[2:0];
    assign dest_idx4 = slot4_dest[2:0];

    assign wr_data1 = slot1_data;
    assign wr_data2 = slot2_data;
    assign wr_data3 = slot3_data;
    assign wr_data4 = slot4_data;

    assign cs_ld  = valid_out & far_xfer;
    assign cs_sel = slot1_data[47:32]; // far target selector

    // lowest memory slot wins
    always_comb begin
        push_addr = slot1_dest;
        push_data = slot1_data;
        if (slot1_is_mem) begin
            push_addr = slot1_dest;
            push_data = slot1_data;
        end else if (slot2_is_mem) begin
            push_addr = slot2_dest;
            push_data = slot2_data;
        end else if (slot3_is_mem) begin
            push_addr = slot3_dest;
            push_data = slot3_data;
        end else if (slot4_is_mem) begin
            push_addr = slot4_dest;
            push_data = slot4_data;
        end
    end

    assign push      = valid_out & (|is_mem);
    assign push_size = far_xfer ? 2'd3 : op_size; // far push is cs:eip

    assign target_eip = far_xfer ? slot1_data[31:0] : br_fip;
    assign new_eip    = br_taken_in ? target_eip : eip_in;

    assign fip_al    = {br_fip[31:4], 4'd0};
    assign fip_p1_al = {br_fip_p1[31:4], 4'd0};
    assign new_fip_e = br_fip[`WB_LINE_BIT] ? fip_p1_al : fip_al;
    assign new_fip_o = br_fip[`WB_LINE_BIT] ? fip_al : fip_p1_al;

    assign is_resteer = valid_out & br_valid_in & ~br_correct_in;

    assign final_ie_val  = ie_in | interrupt_in;
    assign final_ie_type = {interrupt_in, ie_type_in[2:0]}; // bit 3 flags external irq

endmodule

// ==== rtl/gpr_file.sv ====
`timescale 1ns/100ps
`include "wb_macros.svh"

module gpr_file
    import arch_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] ld,
    input  reg_idx_t   idx1,
    input  reg_idx_t   idx2,
    input  reg_idx_t   idx3,
    input  reg_idx_t   idx4,
    input  slot_data_t data1,
    input  slot_data_t data2,
    input  slot_data_t data3,
    input  slot_data_t data4,
    input  op_size_t   size,
    input  reg_idx_t   rd_idx,
    output gpr_val_t   rd_data
);

    gpr_val_t   regs [`WB_NUM_REGS];
    reg_idx_t   idx_a [4];
    slot_data_t data_a [4];

    assign idx_a  = '{idx1, idx2, idx3, idx4};
    assign data_a = '{data1, data2, data3, data4};

    // partial writes keep the untouched upper bits
    function automatic gpr_val_t merge(gpr_val_t old, slot_data_t val, op_size_t sz);
        gpr_val_t res;
        case (sz)
            2'd0:    res = {old[31:8], val[7:0]};
            2'd1:    res = {old[31:16], val[15:0]};
            default: res = val[31:0]; // qword keeps low dword
        endcase
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `WB_NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int s = 0; s < 4; s++) begin // later slot overrides
                if (ld[s]) begin
                    regs[idx_a[s]] <= merge(regs[idx_a[s]], data_a[s], size);
                end
            end
        end
    end

    assign rd_data = regs[rd_idx];

endmodule

// ==== rtl/seg_file.sv ====
`timescale 1ns/100ps
`include "wb_macros.svh"

module seg_file
    import arch_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] ld,
    input  reg_idx_t   idx1,
    input  reg_idx_t   idx2,
    input  reg_idx_t   idx3,
    input  reg_idx_t   idx4,
    input  slot_data_t data1,
    input  slot_data_t data2,
    input  slot_data_t data3,
    input  slot_data_t data4,
    input  logic       cs_ld,
    input  seg_sel_t   cs_sel,
    input  reg_idx_t   rd_idx,
    output seg_sel_t   rd_data
);

    seg_sel_t   segs [`WB_NUM_REGS];
    reg_idx_t   idx_a [4];
    slot_data_t data_a [4];

    assign idx_a  = '{idx1, idx2, idx3, idx4};
    assign data_a = '{data1, data2, data3, data4};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `WB_NUM_REGS; r++) begin
                segs[r] <= '0;
            end
        end else begin
            for (int s = 0; s < 4; s++) begin
                if (ld[s]) begin
                    segs[idx_a[s]] <= data_a[s][15:0];
                end
            end
            if (cs_ld) begin
                segs[`WB_CS_INDEX] <= cs_sel; // far transfer beats slot writes
            end
        end
    end

    assign rd_data = segs[rd_idx];

endmodule

// ==== rtl/wbaq.sv ====
`timescale 1ns/100ps
`include "wb_macros.svh"

module wbaq
    import arch_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  eip_t       push_addr,
    input  slot_data_t push_data,
    input  op_size_t   push_size,
    input  logic       mem_ack,
    output logic       full,
    output logic       mem_req,
    output eip_t       mem_addr,
    output slot_data_t mem_data,
    output op_size_t   mem_size
);

    localparam int PTR_W = $clog2(`WB_QUEUE_DEPTH);

    wbaq_entry_t    mem [`WB_QUEUE_DEPTH];
    wbaq_entry_t    head;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    drain_state_t   state;
    drain_state_t   state_nxt;
    logic           do_push;
    logic           pop;

    assign full    = (count == (PTR_W + 1)'(`WB_QUEUE_DEPTH));
    assign do_push = push & ~full;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= {push_addr, push_data, push_size};
        end
    end

    // drain handshake on the head entry
    always_comb begin
        state_nxt = state;
        pop       = 1'b0;
        case (state)
            idle: begin
                if (count != '0 && !mem_ack) begin
                    state_nxt = req;
                end
            end
            req: begin
                if (mem_ack) begin
                    state_nxt = wait_release;
                end
            end
            wait_release: begin
                if (!mem_ack) begin // store done on ack release
                    state_nxt = idle;
                    pop       = 1'b1;
                end
            end
            default: state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= idle;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            state <= state_nxt;
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`WB_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`WB_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head     = mem[rd_ptr];
    assign mem_req  = (state == req);
    assign mem_addr = head[97:66];
    assign mem_data = head[65:2];
    assign mem_size = head[1:0];

endmodule

// ==== rtl/wb_top.sv ====
`timescale 1ns/100ps

module wb_top
    import arch_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       valid_in,
    input  p_op_t      p_op,
    input  op_size_t   op_size,
    input  slot_data_t slot1_data,
    input  slot_data_t slot2_data,
    input  slot_data_t slot3_data,
    input  slot_data_t slot4_data,
    input  eip_t       slot1_dest,
    input  eip_t       slot2_dest,
    input  eip_t       slot3_dest,
    input  eip_t       slot4_dest,
    input  logic       slot1_is_reg,
    input  logic       slot2_is_reg,
    input  logic       slot3_is_reg,
    input  logic       slot4_is_reg,
    input  logic       slot1_is_seg,
    input  logic       slot2_is_seg,
    input  logic       slot3_is_seg,
    input  logic       slot4_is_seg,
    input  logic       slot1_is_mem,
    input  logic       slot2_is_mem,
    input  logic       slot3_is_mem,
    input  logic       slot4_is_mem,
    input  logic       slot1_wb,
    input  logic       slot2_wb,
    input  logic       slot3_wb,
    input  logic       slot4_wb,
    input  eip_t       eip_in,
    input  logic       br_valid_in,
    input  logic       br_taken_in,
    input  logic       br_correct_in,
    input  eip_t       br_fip,
    input  eip_t       br_fip_p1,
    input  logic       ie_in,
    input  ie_type_t   ie_type_in,
    input  logic       interrupt_in,
    input  reg_idx_t   gpr_rd_idx,
    input  reg_idx_t   seg_rd_idx,
    input  logic       mem_ack,
    output logic       valid_out,
    output logic       stall,
    output logic       is_resteer,
    output eip_t       new_eip,
    output eip_t       new_fip_e,
    output eip_t       new_fip_o,
    output logic       final_ie_val,
    output ie_type_t   final_ie_type,
    output gpr_val_t   gpr_rd_data,
    output seg_sel_t   seg_rd_data,
    output logic       mem_req,
    output eip_t       mem_addr,
    output slot_data_t mem_data,
    output op_size_t   mem_size
);

    logic [3:0] gpr_ld;
    logic [3:0] seg_ld;
    reg_idx_t   dest_idx1;
    reg_idx_t   dest_idx2;
    reg_idx_t   dest_idx3;
    reg_idx_t   dest_idx4;
    slot_data_t wr_data1;
    slot_data_t wr_data2;
    slot_data_t wr_data3;
    slot_data_t wr_data4;
    logic       cs_ld;
    seg_sel_t   cs_sel;
    logic       push;
    eip_t       push_addr;
    slot_data_t push_data;
    op_size_t   push_size;
    logic       full;

    writeback_stage i_stage (
        .valid_in      (valid_in),
        .p_op          (p_op),
        .op_size       (op_size),
        .slot1_data    (slot1_data),
        .slot2_data    (slot2_data),
        .slot3_data    (slot3_data),
        .slot4_data    (slot4_data),
        .slot1_dest    (slot1_dest),
        .slot2_dest    (slot2_dest),
        .slot3_dest    (slot3_dest),
        .slot4_dest    (slot4_dest),
        .slot1_is_reg  (slot1_is_reg),
        .slot2_is_reg  (slot2_is_reg),
        .slot3_is_reg  (slot3_is_reg),
        .slot4_is_reg  (slot4_is_reg),
        .slot1_is_seg  (slot1_is_seg),
        .slot2_is_seg  (slot2_is_seg),
        .slot3_is_seg  (slot3_is_seg),
        .slot4_is_seg  (slot4_is_seg),
        .slot1_is_mem  (slot1_is_mem),
        .slot2_is_mem  (slot2_is_mem),
        .slot3_is_mem  (slot3_is_mem),
        .slot4_is_mem  (slot4_is_mem),
        .slot1_wb      (slot1_wb),
        .slot2_wb      (slot2_wb),
        .slot3_wb      (slot3_wb),
        .slot4_wb      (slot4_wb),
        .eip_in        (eip_in),
        .br_valid_in   (br_valid_in),
        .br_taken_in   (br_taken_in),
        .br_correct_in (br_correct_in),
        .br_fip        (br_fip),
        .br_fip_p1     (br_fip_p1),
        .ie_in         (ie_in),
        .ie_type_in    (ie_type_in),
        .interrupt_in  (interrupt_in),
        .full          (full),
        .valid_out     (valid_out),
        .stall         (stall),
        .gpr_ld        (gpr_ld),
        .seg_ld        (seg_ld),
        .dest_idx1     (dest_idx1),
        .dest_idx2     (dest_idx2),
        .dest_idx3     (dest_idx3),
        .dest_idx4     (dest_idx4),
        .wr_data1      (wr_data1),
        .wr_data2      (wr_data2),
        .wr_data3      (wr_data3),
        .wr_data4      (wr_data4),
        .cs_ld         (cs_ld),
        .cs_sel        (cs_sel),
        .push          (push),
        .push_addr     (push_addr),
        .push_data     (push_data),
        .push_size     (push_size),
        .is_resteer    (is_resteer),
        .new_eip       (new_eip),
        .new_fip_e     (new_fip_e),
        .new_fip_o     (new_fip_o),
        .final_ie_val  (final_ie_val),
        .final_ie_type (final_ie_type)
    );

    gpr_file i_gpr (
        .clk     (clk),
        .rst     (rst),
        .ld      (gpr_ld),
        .idx1    (dest_idx1),
        .idx2    (dest_idx2),
        .idx3    (dest_idx3),
        .idx4    (dest_idx4),
        .data1   (wr_data1),
        .data2   (wr_data2),
        .data3   (wr_data3),
        .data4   (wr_data4),
        .size    (op_size),
        .rd_idx  (gpr_rd_idx),
        .rd_data (gpr_rd_data)
    );

    seg_file i_seg (
        .clk     (clk),
        .rst     (rst),
        .ld      (seg_ld),
        .idx1    (dest_idx1),
        .idx2    (dest_idx2),
        .idx3    (dest_idx3),
        .idx4    (dest_idx4),
        .data1   (wr_data1),
        .data2   (wr_data2),
        .data3   (wr_data3),
        .data4   (wr_data4),
        .cs_ld   (cs_ld),
        .cs_sel  (cs_sel),
        .rd_idx  (seg_rd_idx),
        .rd_data (seg_rd_data)
    );

    wbaq i_wbaq (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_addr (push_addr),
        .push_data (push_data),
        .push_size (push_size),
        .mem_ack   (mem_ack),
        .full      (full),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_data  (mem_data),
        .mem_size  (mem_size)
    );

endmodule

// ==== test/wb_chk.sv ====
`timescale 1ns/100ps

module wb_chk
    import arch_pkg::*;
    import pipe_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       valid_out,
    input logic       stall,
    input logic       is_resteer,
    input logic       mem_req,
    input logic       mem_ack,
    input eip_t       mem_addr,
    input slot_data_t mem_data,
    input op_size_t   mem_size
);

    int fails = 0; // failure count, picked up by the testbench

    req_until_ack: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |=> mem_req)
    else begin
        fails++;
        $error("mem_req dropped before mem_ack rose");
    end

    req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req |=> $stable(mem_addr) && $stable(mem_data) && $stable(mem_size))
    else begin
        fails++;
        $error("store address, data or size changed during the handshake");
    end

    // no new request until memory has released ack
    no_req_under_ack: assert property (@(posedge clk) disable iff (rst)
        mem_ack && !mem_req |=> !mem_req)
    else begin
        fails++;
        $error("mem_req raised while mem_ack still high");
    end

    stall_blocks: assert property (@(posedge clk) disable iff (rst)
        stall |-> !valid_out)
    else begin
        fails++;
        $error("valid_out high during stall");
    end

    reset_quiet: assert property (@(posedge clk)
        rst || $fell(rst) |-> !valid_out && !mem_req && !is_resteer)
    else begin
        fails++;
        $error("outputs active in or just after reset");
    end

endmodule

bind wb_top wb_chk i_chk (
    .clk        (clk),
    .rst        (rst),
    .valid_out  (valid_out),
    .stall      (stall),
    .is_resteer (is_resteer),
    .mem_req    (mem_req),
    .mem_ack    (mem_ack),
    .mem_addr   (mem_addr),
    .mem_data   (mem_data),
    .mem_size   (mem_size)
);

// ==== test/wb_tb.sv ====
`timescale 1ns/100ps
`include "wb_macros.svh"

module wb_tb
    import arch_pkg::*;
    import pipe_pkg::*;
();

    localparam int MAX_CYCLES = 3000; // about twice the sequence at slowest ack

    logic        clk;
    logic        rst;
    logic        valid_in;
    p_op_t       p_op;
    op_size_t    op_size;
    slot_data_t  s_data [1:4];
    eip_t        s_dest [1:4];
    logic [4:1]  s_reg;
    logic [4:1]  s_seg;
    logic [4:1]  s_mem;
    logic [4:1]  s_wb;
    eip_t        eip_in;
    logic        br_valid_in;
    logic        br_taken_in;
    logic        br_correct_in;
    eip_t        br_fip;
    eip_t        br_fip_p1;
    logic        ie_in;
    ie_type_t    ie_type_in;
    logic        interrupt_in;
    reg_idx_t    gpr_rd_idx;
    reg_idx_t    seg_rd_idx;
    logic        mem_ack;
    logic        valid_out;
    logic        stall;
    logic        is_resteer;
    eip_t        new_eip;
    eip_t        new_fip_e;
    eip_t        new_fip_o;
    logic        final_ie_val;
    ie_type_t    final_ie_type;
    gpr_val_t    gpr_rd_data;
    seg_sel_t    seg_rd_data;
    logic        mem_req;
    eip_t        mem_addr;
    slot_data_t  mem_data;
    op_size_t    mem_size;

    gpr_val_t    shadow_gpr [`WB_NUM_REGS];
    seg_sel_t    shadow_seg [`WB_NUM_REGS];
    wbaq_entry_t exp_q [$]; // stores in push order
    int          pushed = 0;
    int          completed = 0;
    int          errors = 0;
    int          cycles = 0;
    int          ack_delay = 1;

    wb_top i_wb_top (
        .*,
        .slot1_data (s_data[1]), .slot1_dest (s_dest[1]), .slot1_is_reg (s_reg[1]),
        .slot1_is_seg (s_seg[1]), .slot1_is_mem (s_mem[1]), .slot1_wb (s_wb[1]),
        .slot2_data (s_data[2]), .slot2_dest (s_dest[2]), .slot2_is_reg (s_reg[2]),
        .slot2_is_seg (s_seg[2]), .slot2_is_mem (s_mem[2]), .slot2_wb (s_wb[2]),
        .slot3_data (s_data[3]), .slot3_dest (s_dest[3]), .slot3_is_reg (s_reg[3]),
        .slot3_is_seg (s_seg[3]), .slot3_is_mem (s_mem[3]), .slot3_wb (s_wb[3]),
        .slot4_data (s_data[4]), .slot4_dest (s_dest[4]), .slot4_is_reg (s_reg[4]),
        .slot4_is_seg (s_seg[4]), .slot4_is_mem (s_mem[4]), .slot4_wb (s_wb[4])
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    initial begin
        wait (cycles >= MAX_CYCLES);
        $display("timeout: tests did not finish");
        $display("errors: %0d checks, %0d assertions, 1 timeout", errors, i_wb_top.i_chk.fails);
        $display("Test failures found");
        $finish;
    end

    task automatic flag_error(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        errors++;
    endtask

    function automatic logic is_far(input p_op_t op);
        return op[`WB_POP_FAR_JMP] | op[`WB_POP_FAR_CALL] | op[`WB_POP_FAR_RET];
    endfunction

    // byte, word or full dword replace
    function automatic gpr_val_t sized_write(input gpr_val_t old, input slot_data_t val,
                                             input op_size_t sz);
        gpr_val_t mask;
        mask = (sz == 2'd0) ? 32'h0000_00ff : (sz == 2'd1) ? 32'h0000_ffff : 32'hffff_ffff;
        return (old & ~mask) | (val[31:0] & mask);
    endfunction

    task automatic new_instr();
        valid_in      <= 1'b1;
        p_op          <= '0;
        op_size       <= 2'd2;
        s_reg         <= '0;
        s_seg         <= '0;
        s_mem         <= '0;
        s_wb          <= '0;
        for (int n = 1; n <= 4; n++) begin
            s_data[n] <= '0;
            s_dest[n] <= '0;
        end
        eip_in        <= 32'h0000_1000;
        br_valid_in   <= 1'b0;
        br_taken_in   <= 1'b0;
        br_correct_in <= 1'b0;
        br_fip        <= 32'h0000_2008;
        br_fip_p1     <= 32'h0000_2018;
        ie_in         <= 1'b0;
        ie_type_in    <= '0;
        interrupt_in  <= 1'b0;
    endtask

    task automatic set_slot(input int n, input logic r, input logic s, input logic m,
                            input logic w, input eip_t dest, input slot_data_t data);
        s_reg[n]  <= r;
        s_seg[n]  <= s;
        s_mem[n]  <= m;
        s_wb[n]   <= w;
        s_dest[n] <= dest;
        s_data[n] <= data;
    endtask

    // shadow state update on the commit edge
    task automatic commit();
        gpr_val_t old_gpr [`WB_NUM_REGS];
        int       m;
        old_gpr = shadow_gpr;
        for (int n = 1; n <= 4; n++) begin
            if (s_reg[n] && s_wb[n]) begin
                shadow_gpr[s_dest[n][2:0]] = sized_write(old_gpr[s_dest[n][2:0]],
                                                         s_data[n], op_size);
            end
            if (s_seg[n] && s_wb[n]) begin
                shadow_seg[s_dest[n][2:0]] = s_data[n][15:0];
            end
        end
        if (is_far(p_op)) begin
            shadow_seg[`WB_CS_INDEX] = s_data[1][47:32];
        end
        m = 0;
        for (int n = 4; n >= 1; n--) begin
            if (s_mem[n]) m = n;
        end
        if (m != 0) begin
            exp_q.push_back({s_dest[m], s_data[m], is_far(p_op) ? 2'd3 : op_size});
            pushed++;
        end
    endtask

    task automatic retire();
        logic exp_stall;
        logic exp_valid;
        eip_t exp_eip;
        eip_t line_e;
        eip_t line_o;
        bit   done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            exp_stall = (pushed - completed == `WB_QUEUE_DEPTH) && valid_in && (s_mem != '0);
            exp_valid = valid_in && !exp_stall;
            exp_eip   = !br_taken_in ? eip_in : (is_far(p_op) ? s_data[1][31:0] : br_fip);
            line_e    = br_fip_p1[`WB_LINE_BIT] ? br_fip : br_fip_p1;
            line_o    = br_fip_p1[`WB_LINE_BIT] ? br_fip_p1 : br_fip;
            assert (stall == exp_stall && valid_out == exp_valid)
                else flag_error($sformatf("stall %b valid_out %b, expected %b %b",
                                          stall, valid_out, exp_stall, exp_valid));
            assert (new_eip == exp_eip)
                else flag_error($sformatf("new_eip %h, expected %h", new_eip, exp_eip));
            assert (new_fip_e == (line_e & ~32'hf) && new_fip_o == (line_o & ~32'hf))
                else flag_error($sformatf("fetch lines %h/%h, br_fip %h", new_fip_e,
                                          new_fip_o, br_fip));
            assert (is_resteer == (exp_valid && br_valid_in && !br_correct_in))
                else flag_error($sformatf("is_resteer %b", is_resteer));
            assert (final_ie_val == (ie_in | interrupt_in)
                    && final_ie_type == {interrupt_in, ie_type_in[2:0]})
                else flag_error($sformatf("ie %b/%h for ie_in %b irq %b", final_ie_val,
                                          final_ie_type, ie_in, interrupt_in));
            @(posedge clk);
            if (exp_valid) begin
                commit();
                done = 1'b1;
            end
        end
    endtask

    task automatic hold_invalid();
        valid_in <= 1'b0;
        @(negedge clk);
        assert (!valid_out && !stall && !is_resteer)
            else flag_error("outputs active with valid_in low");
        @(posedge clk);
    endtask

    task automatic check_regs();
        valid_in <= 1'b0;
        for (int r = 0; r < `WB_NUM_REGS; r++) begin
            gpr_rd_idx <= r[2:0];
            seg_rd_idx <= r[2:0];
            @(negedge clk);
            assert (gpr_rd_data == shadow_gpr[r])
                else flag_error($sformatf("gpr %0d = %h, expected %h", r, gpr_rd_data,
                                          shadow_gpr[r]));
            assert (seg_rd_data == shadow_seg[r])
                else flag_error($sformatf("seg %0d = %h, expected %h", r, seg_rd_data,
                                          shadow_seg[r]));
            @(posedge clk);
        end
    endtask

    task automatic wait_drain();
        valid_in <= 1'b0;
        while (completed != pushed) @(posedge clk);
        repeat (2) @(posedge clk);
        assert (exp_q.size() == 0 && !mem_req)
            else flag_error($sformatf("%0d stores never reached memory", exp_q.size()));
    endtask

    task automatic check_store();
        wbaq_entry_t exp_st;
        if (exp_q.size() == 0) begin
            $display("unexpected store to address %h at %0t", mem_addr, $time);
            errors++;
        end else begin
            exp_st = exp_q.pop_front();
            assert ({mem_addr, mem_data, mem_size} == exp_st)
                else flag_error($sformatf("store %h/%h/%0d, expected %h", mem_addr,
                                          mem_data, mem_size, exp_st));
        end
    endtask

    // four-phase memory responder
    initial begin
        mem_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (mem_req && !mem_ack) begin
                check_store();
                repeat (ack_delay - 1) @(posedge clk);
                mem_ack <= 1'b1;
                do @(posedge clk); while (mem_req);
                mem_ack <= 1'b0;
                @(posedge clk);
                completed++; // queue pops on this edge
            end
        end
    end

    task automatic run_reg_tests();
        check_regs();
        new_instr();
        set_slot(1, 1, 0, 0, 1, 0, 64'h1122_3344);
        set_slot(2, 1, 0, 0, 1, 1, 64'h5566_7788);
        set_slot(3, 1, 0, 0, 1, 2, 64'hdead_beef_99aa_bbcc);
        set_slot(4, 1, 0, 0, 1, 3, 64'h0bad_f00d);
        retire();
        new_instr();
        op_size <= 2'd0;
        set_slot(1, 1, 0, 0, 1, 0, 64'hffff_ffa5);
        set_slot(2, 1, 0, 0, 1, 6, 64'h11);
        set_slot(3, 1, 0, 0, 1, 6, 64'h22); // same register, slot 3 wins
        retire();
        new_instr();
        op_size <= 2'd1;
        set_slot(1, 1, 0, 0, 1, 1, 64'h1234_cafe);
        set_slot(2, 1, 0, 0, 0, 3, 64'h7777_7777); // wb low
        retire();
        new_instr();
        op_size <= 2'd3;
        set_slot(1, 1, 0, 0, 1, 2, 64'h0000_0001);
        set_slot(3, 1, 0, 0, 1, 2, 64'h0000_0002);
        set_slot(4, 1, 0, 0, 1, 4, 64'h1111_2222_3333_4444);
        retire();
        new_instr();
        set_slot(1, 1, 0, 0, 1, 5, 64'h5555_5555);
        hold_invalid();
        check_regs();
    endtask

    task automatic run_seg_tests();
        new_instr();
        set_slot(1, 0, 1, 0, 1, 2, 64'h0001_0018);
        set_slot(2, 0, 1, 0, 1, 3, 64'h0020);
        set_slot(4, 0, 1, 0, 1, 3, 64'h0028);
        retire();
        new_instr();
        p_op[`WB_POP_FAR_JMP] <= 1'b1;
        br_valid_in   <= 1'b1;
        br_taken_in   <= 1'b1;
        br_correct_in <= 1'b1;
        set_slot(1, 0, 0, 0, 0, 0, 64'h0000_0033_0040_1000);
        set_slot(2, 0, 1, 0, 1, `WB_CS_INDEX, 64'h7777); // loses to the CS load
        retire();
        new_instr();
        p_op[`WB_POP_FAR_CALL] <= 1'b1;
        br_taken_in <= 1'b1;
        set_slot(1, 0, 0, 0, 0, 0, 64'h0000_0043_0050_2000);
        set_slot(3, 0, 0, 1, 0, 32'h0000_fff0, 64'h0000_0043_0000_1234);
        retire();
        new_instr();
        p_op[`WB_POP_FAR_RET] <= 1'b1;
        eip_in <= 32'h0000_0600;
        set_slot(1, 0, 0, 0, 0, 0, 64'h0000_0053_0060_3000);
        retire();
        check_regs();
    endtask

    task automatic run_store_tests();
        for (int i = 0; i < 6; i++) begin
            ack_delay = i + 1;
            new_instr();
            op_size <= i[1:0];
            set_slot(i % 4 + 1, 0, 0, 1, 0, 32'h0000_1000 + i * 8,
                     {32'hc0de_0000 + i, 32'h5a5a_0000 + i});
            if (i[0]) set_slot(4, 0, 0, 1, 0, 32'h0000_2000 + i, 64'hffff);
            retire();
        end
        wait_drain();
    endtask

    task automatic run_stall_tests();
        ack_delay = 6;
        for (int i = 0; i < 7; i++) begin
            new_instr();
            set_slot(1, 0, 0, 1, 0, 32'h0000_3000 + i * 4, 64'h100 + i);
            set_slot(2, 1, 0, 0, 1, 7, 64'h0101 * (i + 1));
            retire();
        end
        new_instr();
        set_slot(2, 1, 0, 0, 1, 6, 64'h6666_0000); // queue full, no store offered
        retire();
        new_instr();
        set_slot(1, 0, 0, 1, 0, 32'h0000_3100, 64'h1);
        hold_invalid();
        wait_drain();
        check_regs();
    endtask

    task automatic run_branch_tests();
        eip_t fip;
        for (int i = 0; i < 8; i++) begin
            fip = 32'h0040_0a03 + (i << 3); // line bit toggles with i[1]
            new_instr();
            br_valid_in   <= i[0];
            br_correct_in <= i[1];
            br_taken_in   <= i[2];
            br_fip        <= fip;
            br_fip_p1     <= fip + 32'd16;
            eip_in        <= 32'h0000_8000 + i;
            retire();
        end
        new_instr();
        br_valid_in <= 1'b1;
        hold_invalid();
    endtask

    task automatic run_ie_tests();
        for (int i = 0; i < 4; i++) begin
            new_instr();
            ie_in        <= i[0];
            interrupt_in <= i[1];
            ie_type_in   <= 4'hc + 4'(i);
            retire();
        end
    endtask

    initial begin
        rst = 1'b1;
        for (int r = 0; r < `WB_NUM_REGS; r++) begin
            shadow_gpr[r] = '0;
            shadow_seg[r] = '0;
        end
        new_instr();
        valid_in   <= 1'b0;
        gpr_rd_idx <= '0;
        seg_rd_idx <= '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);
        run_reg_tests();
        run_seg_tests();
        run_store_tests();
        run_stall_tests();
        run_branch_tests();
        run_ie_tests();
        wait_drain();
        $display("errors: %0d checks, %0d assertions", errors, i_wb_top.i_chk.fails);
        if (errors == 0 && i_wb_top.i_chk.fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/arch_pkg.sv
rtl/pipe_pkg.sv
rtl/writeback_stage.sv
rtl/gpr_file.sv
rtl/seg_file.sv
rtl/wbaq.sv
rtl/wb_top.sv
test/wb_chk.sv
test/wb_tb.sv
